// File: dv/rxFrameFsm_props.sv
`timescale 1ns/1ps

module rxFrameFsm_props #(
	parameter int DataBits = 8
) (
	input logic                Clk,
	input logic                Rst,
	input logic [2:0]          state,
	input logic                frameValid,
	input logic                rxValid,
	input logic                rxReady,
	input logic [DataBits-1:0] rxData,
	input logic [2:0]          rxErr,
	input logic                rts
);

	stateLegal: assert property (@(posedge Clk) disable iff (Rst)
		state <= 3'(uartRxPkg::done))
		else $error("receive FSM state is outside the legal range");

	// The done state lasts one cycle, so the push does too.
	framePulse: assert property (@(posedge Clk) disable iff (Rst)
		frameValid |=> !frameValid)
		else $error("frameValid stayed high for more than one cycle");

	stallHold: assert property (@(posedge Clk) disable iff (Rst)
		rxValid && !rxReady |=> rxValid && $stable(rxData) && $stable(rxErr))
		else $error("output byte changed or vanished while stalled");

	rtsAfterReset: assert property (@(posedge Clk) $fell(Rst) |-> rts)
		else $error("rts is low right after reset");

endmodule

// FSM side ties the stream inputs so its stream checks stay quiet.
bind rxFrameFsm rxFrameFsm_props #(.DataBits(DataBits)) fsmProps_i (
	.Clk(Clk),
	.Rst(Rst),
	.state(state),
	.frameValid(frameValid),
	.rxValid(1'b0),
	.rxReady(1'b1),
	.rxData({DataBits{1'b0}}),
	.rxErr(3'b000),
	.rts(1'b1)
);

bind rxFifo rxFrameFsm_props #(.DataBits(DataBits)) fifoProps_i (
	.Clk(Clk),
	.Rst(Rst),
	.state(3'd0),
	.frameValid(push),
	.rxValid(rxValid),
	.rxReady(rxReady),
	.rxData(rxData),
	.rxErr(rxErr),
	.rts(rts)
);

// File: dv/tbUartRx.sv
`timescale 1ns/1ps

module tbUartRx;

	localparam int DataBits  = 8;
	localparam int ClkPeriod = 40;

	logic                Clk;
	logic                Rst;
	logic                cfgValid;
	logic                cfgReady;
	uartRxPkg::regAddr   cfgAddr;
	logic [15:0]         cfgData;
	logic                rxIn;
	logic                rxValid;
	logic                rxReady;
	logic [DataBits-1:0] rxData;
	logic [2:0]          rxErr;
	logic                rts;
	logic                overrun;

	logic [7:0]          cmdOp [$]; // Records in file order, expects excluded.
	int                  cmdA [$];
	int                  cmdB [$];
	int                  cmdC [$];
	logic [DataBits-1:0] expData [$];
	logic [2:0]          expErr [$];

	int     divisor;    // Line format as the bench believes it is configured.
	int     fmtParity;
	logic   twoStop;
	logic   midPending; // A config write to issue in the middle of the next frame.
	int     midAddr;
	int     midData;
	int     seed;
	longint watchdogNs;

	uartRxTop #(.DataBits(DataBits), .DivWidth(16), .FifoDepth(4)) dut_i (
		.Clk(Clk),
		.Rst(Rst),
		.cfgValid(cfgValid),
		.cfgReady(cfgReady),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.rxIn(rxIn),
		.rxValid(rxValid),
		.rxReady(rxReady),
		.rxData(rxData),
		.rxErr(rxErr),
		.rts(rts),
		.overrun(overrun)
	);

	always #(ClkPeriod / 2) Clk = ~Clk;

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic writeConfig(input int addr, input int data);
		cfgAddr  = uartRxPkg::regAddr'(addr[1:0]);
		cfgData  = data[15:0];
		cfgValid = 1'b1;
		@(posedge Clk);
		while (!cfgReady)
			@(posedge Clk);
		#2;
		cfgValid = 1'b0;
		if (addr == 0)
			divisor = data & 16'hffff;
		else if (addr == 1)
		begin
			fmtParity = (data[1:0] == 2'd3) ? 0 : int'(data[1:0]); // Code 3 acts as no parity.
			twoStop   = data[2];
		end
	endtask

	task automatic driveBit(input logic v, input int len);
		rxIn = v;
		repeat (len)
			@(posedge Clk);
		#2;
	endtask

	// ####################
	// Serial frame, MSB first, then an idle gap of random length.
	task automatic sendFrame(input logic [DataBits-1:0] data, input logic parInv,
		input logic [1:0] stops);
		int   len;
		int   par;
		logic two;
		logic parBit;
		int   gap;
		len    = divisor; // Format is fixed before a mid-frame write lands.
		par    = fmtParity;
		two    = twoStop;
		parBit = (par == 2) ? ~^data : ^data;
		parBit = parBit ^ parInv;
		driveBit(1'b0, len);
		for (int i = DataBits - 1; i >= 0; i--)
		begin
			if (midPending && i == DataBits / 2)
			begin
				rxIn       = data[i];
				midPending = 1'b0;
				writeConfig(midAddr, midData);
				repeat (len - 1)
					@(posedge Clk);
				#2;
			end
			else
				driveBit(data[i], len);
		end
		if (par != 0)
			driveBit(parBit, len);
		driveBit(stops[0], len);
		if (two)
			driveBit(stops[1], len);
		gap = len + {$random(seed)} % (2 * len);
		driveBit(1'b1, gap);
	endtask

	task automatic runRecord(input logic [7:0] op, input int a, input int b, input int c);
		case (op)
			"C": writeConfig(a, b);
			"M":
			begin
				midPending = 1'b1;
				midAddr    = a;
				midData    = b;
			end
			"F": sendFrame(a[DataBits-1:0], b[0], c[1:0]);
			"R": rxReady = a[0];
			"O": assert (overrun == a[0])
				else reportFailure($sformatf("FAILED at %0d ns: overrun is %0b, expected %0b",
					$time, overrun, a[0]));
			"T": assert (rts == a[0])
				else reportFailure($sformatf("FAILED at %0d ns: rts is %0b, expected %0b",
					$time, rts, a[0]));
			default: ;
		endcase
	endtask

	// ####################
	// Consumer. Bytes leave in the order of the expect records.
	always @(negedge Clk)
	begin
		if (!Rst && rxValid && rxReady)
		begin
			assert (expData.size() > 0)
			else reportFailure($sformatf("FAILED at %0d ns: unexpected byte %h tag %03b",
				$time, rxData, rxErr));
			assert (rxData == expData[0] && rxErr == expErr[0])
			else reportFailure($sformatf("FAILED at %0d ns: got %h tag %03b, expected %h tag %03b",
				$time, rxData, rxErr, expData[0], expErr[0]));
			void'(expData.pop_front());
			void'(expErr.pop_front());
		end
	end

	initial
	begin
		wait (watchdogNs > 0);
		#(watchdogNs);
		reportFailure($sformatf("timeout: the run did not finish within %0d ns", watchdogNs));
	end

	initial
	begin
		int         fd;
		int         n;
		int         a;
		int         b;
		int         c;
		int         maxDiv;
		logic [7:0] op;
		string      line;
		Clk        = 1'b0;
		Rst        = 1'b1;
		cfgValid   = 1'b0;
		cfgAddr    = uartRxPkg::regDivisor;
		cfgData    = '0;
		rxIn       = 1'b1;
		rxReady    = 1'b1;
		divisor    = 16; // Reset format of the receiver.
		fmtParity  = 0;
		twoStop    = 1'b0;
		midPending = 1'b0;
		seed       = 32'h490a5412;
		maxDiv     = 16;

		fd = $fopen("dv/uartRx_stimulus.txt", "r");
		if (fd == 0)
			reportFailure("cannot open the stimulus file dv/uartRx_stimulus.txt");
		while ($fscanf(fd, " %c", op) == 1)
		begin
			a = 0;
			b = 0;
			c = 0;
			if (op == "#")
				n = $fgets(line, fd);
			else
			begin
				case (op)
					"F":           n = $fscanf(fd, "%h %h %h", a, b, c) - 3;
					"C", "M", "E": n = $fscanf(fd, "%h %h", a, b) - 2;
					"R", "O", "T": n = $fscanf(fd, "%h", a) - 1;
					default:       n = -1;
				endcase
				if (n != 0)
					reportFailure($sformatf("malformed stimulus record starting with %c", op));
				if (op == "E")
				begin
					expData.push_back(a[DataBits-1:0]);
					expErr.push_back(b[2:0]);
				end
				else
				begin
					cmdOp.push_back(op);
					cmdA.push_back(a);
					cmdB.push_back(b);
					cmdC.push_back(c);
				end
				if ((op == "C" || op == "M") && a == 0 && b > maxDiv)
					maxDiv = b;
			end
		end
		$fclose(fd);
		watchdogNs = longint'(cmdOp.size() + expData.size()) * 12 * maxDiv * ClkPeriod + 100000;

		repeat (16)
			@(posedge Clk);
		#2;
		Rst = 1'b0;
		for (int i = 0; i < cmdOp.size(); i++)
			runRecord(cmdOp[i], cmdA[i], cmdB[i], cmdC[i]);

		while (expData.size() != 0)
			@(posedge Clk);
		repeat (4 * divisor)
			@(posedge Clk); // Room for a stray byte to reach the consumer.
		$display("sim passed");
		$finish;
	end

endmodule

// File: dv/uartRx_stimulus.txt
# C addr data | M addr data (write during next frame) | F data parInv stops (bit0 first stop)
# R ready | E data errTag | O overrun | T rts ; all values hex
F a5 0 1
E a5 0
F 3c 0 1
E 3c 0
C 0 a
F 81 0 1
E 81 0
# even, then odd parity
C 1 1
F 96 0 1
E 96 0
F 96 1 1
E 96 2
C 1 2
F 55 0 1
E 55 0
F 55 1 1
E 55 2
# framing and break
C 1 0
F c3 0 0
E c3 4
F 00 0 0
E 00 5
# two stop bits
C 1 4
F 12 0 3
E 12 0
F 34 0 1
E 34 4
# back-pressure and overrun
C 1 0
R 0
F 01 0 1
F 02 0 1
F 03 0 1
T 1
F 04 0 1
T 0
O 0
F 05 0 1
F 06 0 1
O 1
E 01 0
E 02 0
E 03 0
E 04 0
R 1
C 2 0
O 0
# format change in the middle of a frame
M 1 1
F 5a 0 1
E 5a 0
F 5b 0 1
E 5b 0
F 5b 1 1
E 5b 2

// File: list.f
rtl/uartRxPkg.sv
rtl/uartRxConfig.sv
rtl/bitTimer.sv
rtl/rxFrameFsm.sv
rtl/rxFifo.sv
rtl/uartRxTop.sv
dv/rxFrameFsm_props.sv
dv/tbUartRx.sv

// File: rtl/bitTimer.sv
`timescale 1ns/1ps

module bitTimer #(
	parameter int DivWidth = 16
) (
	input  logic                Clk,
	input  logic                Rst,
	input  logic                start,
	input  logic [DivWidth-1:0] divisor,
	output logic                sampleTick
);

	// Enough ticks for the longest 8-bit frame, then the counter parks.
	localparam int MaxTicks = 15;
	localparam int TickW    = $clog2(MaxTicks + 1);

	logic [DivWidth-1:0] count;
	logic [DivWidth-1:0] period; // Divisor captured at the start edge.
	logic [TickW-1:0]    ticksLeft;
	logic                running;

	assign running    = ticksLeft != '0;
	assign sampleTick = running && count == '0;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			count     <= '0;
			ticksLeft <= '0;
		end
		else if (start)
		begin
			count     <= (divisor >> 1) - 1'b1; // First tick lands at mid start bit.
			ticksLeft <= TickW'(MaxTicks);
		end
		else if (sampleTick)
		begin
			count     <= period - 1'b1;
			ticksLeft <= ticksLeft - 1'b1;
		end
		else if (running)
			count <= count - 1'b1;
	end

	always_ff @(posedge Clk)
	begin
		if (start)
			period <= divisor;
	end

endmodule

// File: rtl/rxFifo.sv
`timescale 1ns/1ps

module rxFifo #(
	parameter int DataBits  = 8,
	parameter int FifoDepth = 4
) (
	input  logic                Clk,
	input  logic                Rst,
	input  logic                push,
	input  logic [DataBits-1:0] pushData,
	input  logic [2:0]          pushErr,
	input  logic                rxReady,
	output logic                rxValid,
	output logic [DataBits-1:0] rxData,
	output logic [2:0]          rxErr,
	output logic                rts,
	output logic                dropped
);

	localparam int PtrW   = $clog2(FifoDepth);
	localparam int CountW = $clog2(FifoDepth + 1);
	localparam logic [PtrW-1:0] LastPtr = PtrW'(FifoDepth - 1);

	logic [DataBits+2:0] mem [FifoDepth]; // Error tag above the byte.
	logic [PtrW-1:0]     wrPtr;
	logic [PtrW-1:0]     rdPtr;
	logic [CountW-1:0]   count;
	logic                full;
	logic                doPush;
	logic                doPop;

	assign full    = count == CountW'(FifoDepth);
	assign rxValid = count != '0;
	assign doPush  = push && !full;
	assign doPop   = rxValid && rxReady;
	assign dropped = push && full; // Push has no ready, so the frame is lost.
	assign rts     = !full;

	assign {rxErr, rxData} = mem[rdPtr];

	always_ff @(posedge Clk)
	begin
		if (doPush)
			mem[wrPtr] <= {pushErr, pushData};
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/rxFrameFsm.sv
`timescale 1ns/1ps

module rxFrameFsm #(
	parameter int DataBits = 8,
	parameter int DivWidth = 16
) (
	input  logic                 Clk,
	input  logic                 Rst,
	input  logic                 rxIn,
	input  logic                 sampleTick,
	input  logic [DivWidth-1:0]  divisor,
	input  uartRxPkg::parityMode parity,
	input  logic                 twoStop,
	output logic                 timerStart,
	output logic                 frameValid,
	output logic [DataBits-1:0]  frameData,
	output logic [2:0]           frameErr
);

	localparam int BitCntW = $clog2(DataBits);
	localparam logic [BitCntW-1:0] LastBit = BitCntW'(DataBits - 1);

	uartRxPkg::rxState    state;
	uartRxPkg::rxState    stateNext;
	uartRxPkg::parityMode parityLat;
	logic                 twoStopLat;

	logic                rxMeta;
	logic                rxLine;
	logic                rxPrev;
	logic                startEdge;
	logic                divisorOk;
	logic [BitCntW-1:0]  bitCnt;
	logic                stopCnt;
	logic [DataBits-1:0] dataReg;
	logic                parAcc; // Running XOR of the data bits.
	logic                parRx;
	logic                stopLow;
	logic                parErr;

	// ####################
	// Input synchronizer and start edge.
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			rxMeta <= 1'b1; // Line idles high.
			rxLine <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rxIn;
			rxLine <= rxMeta;
			rxPrev <= rxLine;
		end
	end

	// A divisor below 2 cannot place a mid-bit sample.
	assign divisorOk  = divisor > DivWidth'(1);
	assign startEdge  = rxPrev && !rxLine && divisorOk;
	assign timerStart = (state == uartRxPkg::idle) && startEdge;

	// ####################
	// State machine.
	always_comb
	begin
		stateNext = state;
		case (state)
			uartRxPkg::idle:
				if (startEdge)
					stateNext = uartRxPkg::startBit;
			uartRxPkg::startBit:
				if (sampleTick)
					stateNext = rxLine ? uartRxPkg::idle : uartRxPkg::dataBits; // High is a glitch.
			uartRxPkg::dataBits:
				if (sampleTick && bitCnt == LastBit)
				begin
					if (parityLat == uartRxPkg::parityNone)
						stateNext = uartRxPkg::stopBits;
					else
						stateNext = uartRxPkg::parityBit;
				end
			uartRxPkg::parityBit:
				if (sampleTick)
					stateNext = uartRxPkg::stopBits;
			uartRxPkg::stopBits:
				if (sampleTick && (!twoStopLat || stopCnt))
					stateNext = uartRxPkg::done;
			uartRxPkg::done:
				stateNext = uartRxPkg::idle;
			default:
				stateNext = uartRxPkg::idle;
		endcase
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state      <= uartRxPkg::idle;
			parityLat  <= uartRxPkg::parityNone;
			twoStopLat <= 1'b0;
			bitCnt     <= '0;
			stopCnt    <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (timerStart)
			begin
				parityLat  <= parity; // Format is fixed for the whole frame.
				twoStopLat <= twoStop;
				bitCnt     <= '0;
				stopCnt    <= 1'b0;
			end
			else if (sampleTick)
			begin
				if (state == uartRxPkg::dataBits)
					bitCnt <= bitCnt + 1'b1;
				if (state == uartRxPkg::stopBits)
					stopCnt <= 1'b1;
			end
		end
	end

	// Shift register, MSB first, and the sampled parity and stop bits.
	always_ff @(posedge Clk)
	begin
		if (timerStart)
		begin
			parAcc  <= 1'b0;
			parRx   <= 1'b0;
			stopLow <= 1'b0;
		end
		else if (sampleTick)
		begin
			case (state)
				uartRxPkg::dataBits:
				begin
					dataReg <= {dataReg[DataBits-2:0], rxLine};
					parAcc  <= parAcc ^ rxLine;
				end
				uartRxPkg::parityBit:
					parRx <= rxLine;
				uartRxPkg::stopBits:
					stopLow <= stopLow | !rxLine;
				default: ;
			endcase
		end
	end

	// ####################
	// Error tag and output.
	always_comb
	begin
		case (parityLat)
			uartRxPkg::parityEven: parErr = parAcc ^ parRx;
			uartRxPkg::parityOdd:  parErr = !(parAcc ^ parRx);
			default:               parErr = 1'b0;
		endcase
	end

	always_comb
	begin
		frameErr = 3'b000;
		if (state == uartRxPkg::done)
		begin
			frameErr[uartRxPkg::errFraming] = stopLow;
			frameErr[uartRxPkg::errParity]  = parErr;
			frameErr[uartRxPkg::errBreak]   = stopLow && (dataReg == '0);
		end
	end

	assign frameValid = state == uartRxPkg::done;
	assign frameData  = dataReg;

endmodule

// File: rtl/uartRxConfig.sv
`timescale 1ns/1ps

module uartRxConfig #(
	parameter int DivWidth = 16
) (
	input  logic                 Clk,
	input  logic                 Rst,
	input  logic                 cfgValid,
	output logic                 cfgReady,
	input  uartRxPkg::regAddr    cfgAddr,
	input  logic [15:0]          cfgData,
	input  logic                 dropped,
	output logic [DivWidth-1:0]  divisor,
	output uartRxPkg::parityMode parity,
	output logic                 twoStop,
	output logic                 overrun
);

	logic cfgWrite;

	assign cfgReady = 1'b1; // Registers accept a write every cycle.
	assign cfgWrite = cfgValid && cfgReady;

	// ####################
	// Format and divisor registers.
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			divisor <= DivWidth'(16);
			parity  <= uartRxPkg::parityNone;
			twoStop <= 1'b0;
		end
		else if (cfgWrite)
		begin
			case (cfgAddr)
				uartRxPkg::regDivisor:
					divisor <= cfgData[DivWidth-1:0];
				uartRxPkg::regFormat:
				begin
					if (cfgData[1:0] == 2'd3)
						parity <= uartRxPkg::parityNone; // Unused code means no parity.
					else
						parity <= uartRxPkg::parityMode'(cfgData[1:0]);
					twoStop <= cfgData[2];
				end
				default: ;
			endcase
		end
	end

	// Sticky overrun; a drop in the same cycle as a clear wins.
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			overrun <= 1'b0;
		else if (dropped)
			overrun <= 1'b1;
		else if (cfgWrite && cfgAddr == uartRxPkg::regClear)
			overrun <= 1'b0;
	end

endmodule

// File: rtl/uartRxPkg.sv
package uartRxPkg;

	// Parity sense taken from the format register, bits 1:0.
	typedef enum logic [1:0]
	{
		parityNone = 2'd0,
		parityEven = 2'd1,
		parityOdd  = 2'd2
	} parityMode;

	// Writable register map.
	typedef enum logic [1:0]
	{
		regDivisor = 2'd0, // Bit period in clocks.
		regFormat  = 2'd1, // Parity in 1:0, two stop bits in 2.
		regClear   = 2'd2  // Any write clears overrun.
	} regAddr;

	typedef enum logic [2:0]
	{
		idle      = 3'd0,
		startBit  = 3'd1,
		dataBits  = 3'd2,
		parityBit = 3'd3,
		stopBits  = 3'd4,
		done      = 3'd5
	} rxState;

	// Bit positions in the 3-bit error tag.
	localparam int errFraming = 2;
	localparam int errParity  = 1;
	localparam int errBreak   = 0;

endpackage

// File: rtl/uartRxTop.sv
`timescale 1ns/1ps

module uartRxTop #(
	parameter int DataBits  = 8,
	parameter int DivWidth  = 16,
	parameter int FifoDepth = 4
) (
	input  logic                Clk,
	input  logic                Rst,
	input  logic                cfgValid,
	output logic                cfgReady,
	input  uartRxPkg::regAddr   cfgAddr,
	input  logic [15:0]         cfgData,
	input  logic                rxIn,
	output logic                rxValid,
	input  logic                rxReady,
	output logic [DataBits-1:0] rxData,
	output logic [2:0]          rxErr,
	output logic                rts,
	output logic                overrun
);

	logic [DivWidth-1:0]  divisor;
	uartRxPkg::parityMode parity;
	logic                 twoStop;
	logic                 dropped;
	logic                 timerStart;
	logic                 sampleTick;
	logic                 frameValid;
	logic [DataBits-1:0]  frameData;
	logic [2:0]           frameErr;

	uartRxConfig #(.DivWidth(DivWidth)) config_i (
		.Clk(Clk),
		.Rst(Rst),
		.cfgValid(cfgValid),
		.cfgReady(cfgReady),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.dropped(dropped),
		.divisor(divisor),
		.parity(parity),
		.twoStop(twoStop),
		.overrun(overrun)
	);

	bitTimer #(.DivWidth(DivWidth)) timer_i (
		.Clk(Clk),
		.Rst(Rst),
		.start(timerStart),
		.divisor(divisor),
		.sampleTick(sampleTick)
	);

	rxFrameFsm #(.DataBits(DataBits), .DivWidth(DivWidth)) fsm_i (
		.Clk(Clk),
		.Rst(Rst),
		.rxIn(rxIn),
		.sampleTick(sampleTick),
		.divisor(divisor),
		.parity(parity),
		.twoStop(twoStop),
		.timerStart(timerStart),
		.frameValid(frameValid),
		.frameData(frameData),
		.frameErr(frameErr)
	);

	rxFifo #(.DataBits(DataBits), .FifoDepth(FifoDepth)) fifo_i (
		.Clk(Clk),
		.Rst(Rst),
		.push(frameValid),
		.pushData(frameData),
		.pushErr(frameErr),
		.rxReady(rxReady),
		.rxValid(rxValid),
		.rxData(rxData),
		.rxErr(rxErr),
		.rts(rts),
		.dropped(dropped)
	);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbUartRx -f list.f -o simUartRx || exit 1
out=$(./obj_dir/simUartRx 2>&1)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
